// File: common/mandel_defines.svh
`ifndef MANDEL_DEFINES_SVH
`define MANDEL_DEFINES_SVH

// signed Q4.12 coordinates, range +/-8
`define COORD_W   16
`define FRAC_BITS 12

// iteration limit, also the count reported for points inside the set
`define MAX_ITER  255

// frame geometry
`define IMG_W     16
`define IMG_H     12
`define PX_W      5     // wide enough for column and row numbers

`endif

// File: common/mandel_pkg.sv
`include "mandel_defines.svh"

package mandel_pkg;

   // one coordinate in Q4.12
   typedef logic signed [`COORD_W-1:0] fixed_t;

   // raster walker
   typedef enum logic [1:0] {
      SCAN_IDLE,
      SCAN_ISSUE,    // launch iterator for current pixel
      SCAN_WAIT,     // iterator busy
      SCAN_FINISH    // frame done strobe
   } scanState_t;

   // escape-time loop
   typedef enum logic [1:0] {
      ITER_IDLE,
      ITER_CHECK,    // one test and update per cycle
      ITER_REPORT
   } iterState_t;

endpackage

// File: src/pixel2color.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module pixel2color (
   input  logic [7:0]  pixel,
   output logic [31:0] color
);

   logic [7:0] red;
   logic [7:0] green;
   logic [7:0] blue;

   // 00RRGGBB
   assign color = {8'h00, red, green, blue};

   always_comb begin
      if (pixel == 8'(`MAX_ITER)) begin
         // never escaped, inside the set
         {red, green, blue} = 24'h000000;
      end else if (pixel == 8'd0) begin
         {red, green, blue} = 24'hFFFFFF;   // escaped immediately
      end else begin
         // band picked by upper nibble
         case (pixel[7:4])
            4'd0:    {red, green, blue} = 24'hFF0000;   // red
            4'd1:    {red, green, blue} = 24'hFF3300;
            4'd2:    {red, green, blue} = 24'hFF6600;   // orange
            4'd3:    {red, green, blue} = 24'hFF9900;
            4'd4:    {red, green, blue} = 24'hFFFF00;   // yellow
            4'd5:    {red, green, blue} = 24'hCCFF00;
            4'd6:    {red, green, blue} = 24'h00FF00;   // green
            4'd7:    {red, green, blue} = 24'h00FF99;
            4'd8:    {red, green, blue} = 24'h00CCFF;   // blue
            4'd9:    {red, green, blue} = 24'h0000FF;
            4'd10:   {red, green, blue} = 24'h6666FF;
            4'd11:   {red, green, blue} = 24'hCC66FF;
            4'd12:   {red, green, blue} = 24'hCC0099;   // dark pink
            4'd13:   {red, green, blue} = 24'h990099;
            4'd14:   {red, green, blue} = 24'h660099;   // purple
            default: {red, green, blue} = 24'h330033;
         endcase
      end
   end

endmodule

// File: iterator/escapeIterator.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module escapeIterator (
   input  logic               clk,
   input  logic               rstN,
   input  logic               iterStart,
   input  mandel_pkg::fixed_t cRe,
   input  mandel_pkg::fixed_t cIm,
   output logic               iterDone,
   output logic [7:0]         iterCount
);
   import mandel_pkg::*;

   localparam int PROD_W = 2 * `COORD_W;
   // 4.0 in the shifted product scale
   localparam logic signed [PROD_W-1:0] ESCAPE_LIMIT = PROD_W'(4 << `FRAC_BITS);

   iterState_t state;
   fixed_t     zr;
   fixed_t     zi;
   fixed_t     cReReg;
   fixed_t     cImReg;
   logic [7:0] count;

   logic signed [PROD_W-1:0] prodRr;
   logic signed [PROD_W-1:0] prodIi;
   logic signed [PROD_W-1:0] prodRi;
   logic signed [PROD_W-1:0] sqRe;
   logic signed [PROD_W-1:0] sqIm;
   logic signed [PROD_W-1:0] crossTerm;
   logic signed [PROD_W-1:0] magSq;
   logic signed [PROD_W-1:0] nextReFull;
   logic signed [PROD_W-1:0] nextImFull;
   logic                     escaped;
   logic                     atLimit;
   logic                     stop;

   // three multipliers at double width
   assign prodRr = zr * zr;
   assign prodIi = zi * zi;
   assign prodRi = zr * zi;

   assign sqRe      = prodRr >>> `FRAC_BITS;
   assign sqIm      = prodIi >>> `FRAC_BITS;
   assign crossTerm = prodRi >>> `FRAC_BITS;

   assign magSq   = sqRe + sqIm;
   assign escaped = magSq > ESCAPE_LIMIT;   // strictly outside radius 2
   assign atLimit = (count == 8'(`MAX_ITER));
   assign stop    = escaped || atLimit;

   // z^2 + c, truncated below
   assign nextReFull = sqRe - sqIm + cReReg;
   assign nextImFull = (crossTerm <<< 1) + cImReg;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= ITER_IDLE;
         count <= '0;
      end else begin
         case (state)
            ITER_IDLE: begin
               if (iterStart) begin
                  count <= '0;
                  state <= ITER_CHECK;
               end
            end
            ITER_CHECK: begin
               if (stop) begin
                  state <= ITER_REPORT;   // count frozen here
               end else begin
                  count <= count + 1'b1;
               end
            end
            ITER_REPORT: state <= ITER_IDLE;
            default:     state <= ITER_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ITER_IDLE && iterStart) begin
         zr     <= cRe;   // z0 = c
         zi     <= cIm;
         cReReg <= cRe;
         cImReg <= cIm;
      end else if (state == ITER_CHECK && !stop) begin
         zr <= nextReFull[`COORD_W-1:0];
         zi <= nextImFull[`COORD_W-1:0];
      end
   end

   // done is count+2 cycles after iterStart
   assign iterDone  = (state == ITER_REPORT);
   assign iterCount = count;

endmodule

// File: src/pixelScanner.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module pixelScanner (
   input  logic               clk,
   input  logic               rstN,
   input  logic               start,
   input  mandel_pkg::fixed_t xStart,
   input  mandel_pkg::fixed_t yStart,
   input  mandel_pkg::fixed_t step,
   input  logic               iterDone,
   input  logic [7:0]         iterCount,
   output logic               iterStart,
   output mandel_pkg::fixed_t cRe,
   output mandel_pkg::fixed_t cIm,
   output logic               busy,
   output logic               pixelValid,
   output logic [`PX_W-1:0]   pixelX,
   output logic [`PX_W-1:0]   pixelY,
   output logic [7:0]         pixelCount,
   output logic               frameDone
);
   import mandel_pkg::*;

   localparam logic [`PX_W-1:0] LAST_COL = `PX_W'(`IMG_W - 1);
   localparam logic [`PX_W-1:0] LAST_ROW = `PX_W'(`IMG_H - 1);

   scanState_t       state;
   logic [`PX_W-1:0] col;
   logic [`PX_W-1:0] row;
   fixed_t           rowStart;   // xStart captured at frame start
   fixed_t           stepReg;
   logic             accept;
   logic             pixelDone;
   logic             lastCol;
   logic             lastRow;

   assign accept    = (state == SCAN_IDLE) && start;   // start ignored unless idle
   assign pixelDone = (state == SCAN_WAIT) && iterDone;
   assign lastCol   = (col == LAST_COL);
   assign lastRow   = (row == LAST_ROW);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state      <= SCAN_IDLE;
         busy       <= 1'b0;
         iterStart  <= 1'b0;
         pixelValid <= 1'b0;
         frameDone  <= 1'b0;
         col        <= '0;
         row        <= '0;
      end else begin
         // strobes default low
         iterStart  <= 1'b0;
         pixelValid <= 1'b0;
         frameDone  <= 1'b0;
         case (state)
            SCAN_IDLE: begin
               if (accept) begin
                  busy  <= 1'b1;
                  col   <= '0;
                  row   <= '0;
                  state <= SCAN_ISSUE;
               end
            end
            SCAN_ISSUE: begin
               iterStart <= 1'b1;   // lands the cycle after pixelValid
               state     <= SCAN_WAIT;
            end
            SCAN_WAIT: begin
               if (iterDone) begin
                  pixelValid <= 1'b1;
                  if (lastCol && lastRow) begin
                     state <= SCAN_FINISH;
                  end else begin
                     state <= SCAN_ISSUE;
                     if (lastCol) begin
                        col <= '0;
                        row <= row + 1'b1;
                     end else begin
                        col <= col + 1'b1;
                     end
                  end
               end
            end
            SCAN_FINISH: begin
               frameDone <= 1'b1;
               busy      <= 1'b0;   // falls together with frameDone
               state     <= SCAN_IDLE;
            end
            default: state <= SCAN_IDLE;
         endcase
      end
   end

   // c accumulators and the output pixel register
   always_ff @(posedge clk) begin
      if (accept) begin
         rowStart <= xStart;
         stepReg  <= step;
         cRe      <= xStart;
         cIm      <= yStart;
      end else if (pixelDone) begin
         pixelX     <= col;
         pixelY     <= row;
         pixelCount <= iterCount;
         if (lastCol) begin
            cRe <= rowStart;           // back to left edge
            cIm <= cIm + stepReg;
         end else begin
            cRe <= cRe + stepReg;      // wraps at COORD_W bits
         end
      end
   end

endmodule

// File: src/mandelbrotEngine.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandelbrotEngine (
   input  logic               clk,
   input  logic               rstN,
   input  logic               start,
   input  mandel_pkg::fixed_t xStart,
   input  mandel_pkg::fixed_t yStart,
   input  mandel_pkg::fixed_t step,
   output logic               busy,
   output logic               pixelValid,
   output logic [`PX_W-1:0]   pixelX,
   output logic [`PX_W-1:0]   pixelY,
   output logic [31:0]        color,
   output logic               frameDone
);
   import mandel_pkg::*;

   fixed_t     cRe;
   fixed_t     cIm;
   logic       iterStart;
   logic       iterDone;
   logic [7:0] iterCount;
   logic [7:0] pixelCount;   // registered count of the pixel on output

   pixelScanner pixelScanner_i (
      .clk        (clk),
      .rstN       (rstN),
      .start      (start),
      .xStart     (xStart),
      .yStart     (yStart),
      .step       (step),
      .iterDone   (iterDone),
      .iterCount  (iterCount),
      .iterStart  (iterStart),
      .cRe        (cRe),
      .cIm        (cIm),
      .busy       (busy),
      .pixelValid (pixelValid),
      .pixelX     (pixelX),
      .pixelY     (pixelY),
      .pixelCount (pixelCount),
      .frameDone  (frameDone)
   );

   escapeIterator escapeIterator_i (
      .clk       (clk),
      .rstN      (rstN),
      .iterStart (iterStart),
      .cRe       (cRe),
      .cIm       (cIm),
      .iterDone  (iterDone),
      .iterCount (iterCount)
   );

   // palette is combinational off the held count
   pixel2color pixel2color_i (
      .pixel (pixelCount),
      .color (color)
   );

endmodule

// File: dv/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
   parameter int PERIOD = 20   // ns
) (
   output logic clk
);

   initial clk = 1'b0;

   // free running, starts low
   always #(PERIOD / 2) clk = ~clk;

endmodule

// File: dv/mandelbrotEngine_asserts.sv
`timescale 1ns/1ps

module mandelbrotEngine_asserts (
   input logic clk,
   input logic rstN,
   input logic iterStart,
   input logic iterDone,
   input logic busy,
   input logic pixelValid,
   input logic frameDone
);

   logic iterActive;   // iterator between its start and its done

   always_ff @(posedge clk) begin
      if (!rstN) begin
         iterActive <= 1'b0;
      end else if (iterStart) begin
         iterActive <= 1'b1;
      end else if (iterDone) begin
         iterActive <= 1'b0;
      end
   end

   pixelValidPulse: assert property (@(posedge clk) disable iff (!rstN)
      pixelValid |=> !pixelValid)
      else $error("pixelValid high in two consecutive cycles");

   iterStartBusy: assert property (@(posedge clk) disable iff (!rstN)
      iterStart |-> busy)
      else $error("iterStart while not busy");

   iterStartIdle: assert property (@(posedge clk) disable iff (!rstN)
      iterStart |-> !iterActive)
      else $error("iterStart while the iterator is still running");

   frameDoneBusy: assert property (@(posedge clk) disable iff (!rstN)
      frameDone |-> !busy)
      else $error("busy still high at frameDone");

endmodule

bind pixelScanner mandelbrotEngine_asserts mandelbrotEngine_asserts_i (
   .clk        (clk),
   .rstN       (rstN),
   .iterStart  (iterStart),
   .iterDone   (iterDone),
   .busy       (busy),
   .pixelValid (pixelValid),
   .frameDone  (frameDone)
);

// File: dv/mandelbrotEngine_tb.sv
`timescale 1ns/1ps
`include "mandel_defines.svh"

module mandelbrotEngine_tb;
   import mandel_pkg::*;

   localparam int FRAME_PIXELS    = `IMG_W * `IMG_H;
   localparam int FRAME_CYCLES    = FRAME_PIXELS * (`MAX_ITER + 4);   // worst case per frame
   localparam int NUM_FRAMES      = 10;
   localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES + 1000;

   logic             clk;
   logic             rstN;
   logic             start;
   fixed_t           xStart;
   fixed_t           yStart;
   fixed_t           step;
   logic             busy;
   logic             pixelValid;
   logic [`PX_W-1:0] pixelX;
   logic [`PX_W-1:0] pixelY;
   logic [31:0]      color;
   logic             frameDone;

   // expected view of the frame in flight
   fixed_t      frameX;
   fixed_t      frameY;
   fixed_t      frameStep;
   int          pixIdx;
   int          zeroCount;
   int          insideCount;
   logic        inFrame;
   logic        expectDone;
   logic [31:0] lfsr;

   clockGen #(.PERIOD(20)) clockGen_i (.clk(clk));

   mandelbrotEngine mandelbrotEngine_i (
      .clk        (clk),
      .rstN       (rstN),
      .start      (start),
      .xStart     (xStart),
      .yStart     (yStart),
      .step       (step),
      .busy       (busy),
      .pixelValid (pixelValid),
      .pixelX     (pixelX),
      .pixelY     (pixelY),
      .color      (color),
      .frameDone  (frameDone)
   );

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
      if (actual !== expected) begin
         $display("FAIL %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
         $display("TB FAILED");
         $fatal(1, "mismatch on %s", what);
      end
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] drawBits(input int n);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < n; i++) begin
         fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr  = {lfsr[30:0], fb};
         value = {value[30:0], fb};
      end
      return value;
   endfunction

   // escape time of one point, z0 = c
   function automatic int escapeCount(input fixed_t cr, input fixed_t ci);
      fixed_t zr;
      fixed_t zi;
      longint rr;
      longint ii;
      longint ri;
      zr = cr;
      zi = ci;
      for (int n = 0; n < `MAX_ITER; n++) begin
         rr = (longint'(zr) * longint'(zr)) >>> `FRAC_BITS;
         ii = (longint'(zi) * longint'(zi)) >>> `FRAC_BITS;
         ri = (longint'(zr) * longint'(zi)) >>> `FRAC_BITS;
         if (rr + ii > 16384)
            return n;   // beyond radius 2
         zr = fixed_t'(rr - ii + longint'(cr));
         zi = fixed_t'(2 * ri + longint'(ci));
      end
      return `MAX_ITER;
   endfunction

   function automatic logic [31:0] paletteColor(input int count);
      logic [23:0] rgb;
      if (count == `MAX_ITER) begin
         rgb = 24'h000000;
      end else if (count == 0) begin
         rgb = 24'hffffff;
      end else begin
         case (count / 16)   // sixteen bands of sixteen counts
            0:       rgb = 24'hff0000;
            1:       rgb = 24'hff3300;
            2:       rgb = 24'hff6600;
            3:       rgb = 24'hff9900;
            4:       rgb = 24'hffff00;
            5:       rgb = 24'hccff00;
            6:       rgb = 24'h00ff00;
            7:       rgb = 24'h00ff99;
            8:       rgb = 24'h00ccff;
            9:       rgb = 24'h0000ff;
            10:      rgb = 24'h6666ff;
            11:      rgb = 24'hcc66ff;
            12:      rgb = 24'hcc0099;
            13:      rgb = 24'h990099;
            14:      rgb = 24'h660099;
            default: rgb = 24'h330033;
         endcase
      end
      return {8'h00, rgb};
   endfunction

   // compares every strobe against the expected raster position and color
   always @(negedge clk) begin : monitor
      int     col;
      int     row;
      int     n;
      fixed_t cr;
      fixed_t ci;
      if (!rstN) begin
         inFrame    = 1'b0;
         expectDone = 1'b0;
      end else begin
         checkValue(32'(frameDone), 32'(expectDone), "frameDone");
         if (expectDone) begin
            checkValue(32'(busy), 32'd0, "busy at frameDone");
            checkValue(pixIdx, FRAME_PIXELS, "pixel strobes in frame");
            inFrame    = 1'b0;
            expectDone = 1'b0;
         end else if (inFrame) begin
            checkValue(32'(busy), 32'd1, "busy during frame");
         end
         if (pixelValid) begin
            checkValue(32'(inFrame), 32'd1, "pixel strobe outside a frame");
            col = pixIdx % `IMG_W;   // column fastest
            row = pixIdx / `IMG_W;
            cr  = fixed_t'(int'(frameX) + col * int'(frameStep));
            ci  = fixed_t'(int'(frameY) + row * int'(frameStep));
            n   = escapeCount(cr, ci);
            checkValue(32'(pixelX), col, "pixelX");
            checkValue(32'(pixelY), row, "pixelY");
            checkValue(color, paletteColor(n), "color");
            if (n == 0)
               zeroCount++;
            if (n == `MAX_ITER)
               insideCount++;
            pixIdx++;
            if (pixIdx == FRAME_PIXELS)
               expectDone = 1'b1;   // frameDone due next cycle
         end
      end
   end

   task automatic startFrame(input fixed_t x, input fixed_t y, input fixed_t s);
      @(posedge clk);
      xStart      <= x;
      yStart      <= y;
      step        <= s;
      start       <= 1'b1;
      frameX      = x;
      frameY      = y;
      frameStep   = s;
      pixIdx      = 0;
      zeroCount   = 0;
      insideCount = 0;
      @(posedge clk);
      start   <= 1'b0;
      inFrame = 1'b1;   // accepted here, busy from now on
   endtask

   task automatic waitFrameDone();
      @(negedge clk);
      while (frameDone !== 1'b1)
         @(negedge clk);
      @(posedge clk);
   endtask

   task automatic runFrame(input fixed_t x, input fixed_t y, input fixed_t s);
      startFrame(x, y, s);
      waitFrameDone();
   endtask

   // step in 1/64 .. 1/8, corner so that both components stay within +/-2
   task automatic runRandomFrame();
      int s;
      int xHi;
      int yHi;
      int x;
      int y;
      s   = 64 + int'(drawBits(16)) % 449;
      xHi = (8192 - (`IMG_W - 1) * s < 2048) ? 8192 - (`IMG_W - 1) * s : 2048;
      yHi = (8192 - (`IMG_H - 1) * s < 2048) ? 8192 - (`IMG_H - 1) * s : 2048;
      x   = -8192 + int'(drawBits(16)) % (xHi + 8193);
      y   = -8192 + int'(drawBits(16)) % (yHi + 8193);
      runFrame(fixed_t'(x), fixed_t'(y), fixed_t'(s));
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the frames did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      lfsr        = 32'he1751b59;
      rstN        = 1'b0;
      start       = 1'b0;
      xStart      = '0;
      yStart      = '0;
      step        = '0;
      frameX      = '0;
      frameY      = '0;
      frameStep   = '0;
      pixIdx      = 0;
      zeroCount   = 0;
      insideCount = 0;
      inFrame     = 1'b0;
      expectDone  = 1'b0;
      repeat (4) @(posedge clk);
      rstN <= 1'b1;

      // x -2.0 .. 0.34, y -0.94 .. 0.78, covers the main cardioid
      runFrame(-16'sd8192, -16'sd3840, 16'sd640);
      checkValue(32'(insideCount > 0), 32'd1, "inside points in classic view");
      repeat (3) runRandomFrame();

      runFrame(-16'sd28672, 16'sd0, 16'sd16);   // x near -7, escapes at once
      checkValue(zeroCount, FRAME_PIXELS, "white pixels in far frame");
      runFrame(16'sd0, 16'sd0, 16'sd0);         // every pixel at the origin
      checkValue(insideCount, FRAME_PIXELS, "black pixels at origin");

      // second start mid-frame with other inputs
      startFrame(-16'sd6144, -16'sd2048, 16'sd256);
      while (pixIdx < 30)
         @(posedge clk);
      start  <= 1'b1;
      xStart <= 16'sd4096;
      yStart <= 16'sd4096;
      step   <= 16'sd100;
      @(posedge clk);
      start <= 1'b0;
      waitFrameDone();

      // reset in the middle of a frame
      startFrame(-16'sd8192, -16'sd3840, 16'sd640);
      while (pixIdx < 20)
         @(posedge clk);
      rstN <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      checkValue(32'(busy), 32'd0, "busy in reset");
      checkValue(32'(pixelValid), 32'd0, "pixelValid in reset");
      checkValue(32'(frameDone), 32'd0, "frameDone in reset");
      repeat (3) @(posedge clk);
      rstN <= 1'b1;
      runFrame(-16'sd6144, -16'sd4096, 16'sd512);

      $display("TB PASSED");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+common
common/mandel_pkg.sv
src/pixel2color.sv
iterator/escapeIterator.sv
src/pixelScanner.sv
src/mandelbrotEngine.sv
dv/clockGen.sv
dv/mandelbrotEngine_asserts.sv
dv/mandelbrotEngine_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = mandelbrotEngine_tb
FILELIST  = filelist.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
